//--- list.f
verilog/icache_cfg_pkg.sv
verilog/icache_l2_pkg.sv
verilog/icache_ifaces.sv
verilog/bram_1r1w.sv
verilog/icache_lookup.sv
verilog/icache_miss_unit.sv
verilog/icache_top.sv
tb/icache_assert.sv
tb/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module icache_tb -o icache_sim

out=$(./obj_dir/icache_sim) || true
echo "$out"
if grep -q 'All tests passed!' <<< "$out"; then
    exit 0
fi
exit 1

//--- tb/icache_assert.sv
`timescale 1ns/100ps

module icache_assert (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  logic                                            l2_req_valid,
    input  logic [icache_l2_pkg::L1_BLOCK_ADDR_WIDTH-1:0]   l2_req_PA29,
    input  logic                                            l2_req_ready
);

    // ------------------------------
    // L2 request channel

    // request and address hold until L2 is ready
    held_until_ready: assert property (
        @(posedge CLK) disable iff (~nRST)
        (l2_req_valid & ~l2_req_ready) |=> (l2_req_valid & $stable(l2_req_PA29))
    ) else $error("L2 request changed or dropped before ready");

    // one request per miss
    drop_after_accept: assert property (
        @(posedge CLK) disable iff (~nRST)
        (l2_req_valid & l2_req_ready) |=> ~l2_req_valid
    ) else $error("L2 request still up after it was accepted");

    // ------------------------------
    // reset

    quiet_in_reset: assert property (
        @(posedge CLK) ~nRST |-> ~l2_req_valid
    ) else $error("L2 request raised during reset");

endmodule

bind icache_top icache_assert protocol_check (
    .CLK(CLK),
    .nRST(nRST),
    .l2_req_valid(l2_req_valid),
    .l2_req_PA29(l2_req_PA29),
    .l2_req_ready(l2_req_ready)
);

//--- tb/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

    import icache_cfg_pkg::*;
    import icache_l2_pkg::*;

    localparam int WAIT_LIMIT = 40;

    // ------------------------------
    // DUT signals

    logic                                       CLK = 1'b0;
    logic                                       nRST;
    logic                                       core_req_valid;
    logic [ICACHE_FETCH_OFFSET_WIDTH-1:0]       core_req_block_offset;
    logic [ICACHE_INDEX_WIDTH-1:0]              core_req_index;
    logic [1:0]                                 core_resp_valid_by_way;
    logic [1:0][ICACHE_TAG_WIDTH-1:0]           core_resp_tag_by_way;
    logic [1:0][ICACHE_FETCH_WIDTH-1:0][7:0]    core_resp_instr_16B_by_way;
    logic                                       core_resp_hit_valid;
    logic                                       core_resp_hit_way;
    logic                                       core_resp_miss_valid;
    logic [ICACHE_TAG_WIDTH-1:0]                core_resp_miss_tag;
    logic                                       l2_req_valid;
    logic [L1_BLOCK_ADDR_WIDTH-1:0]             l2_req_PA29;
    logic                                       l2_req_ready;
    logic                                       l2_resp_valid;
    logic [L1_BLOCK_ADDR_WIDTH-1:0]             l2_resp_PA29;
    logic [L1_BLOCK_SIZE_BITS-1:0]              l2_resp_data256;

    // last response seen by the core model
    logic [1:0]                                 seen_valid;
    logic [1:0][ICACHE_TAG_WIDTH-1:0]           seen_tag;
    logic [1:0][127:0]                          seen_data;

    int checks = 0;
    int errors = 0;

    logic [ICACHE_INDEX_WIDTH-1:0]              idx_a;
    logic [ICACHE_INDEX_WIDTH-1:0]              idx_c;
    logic [ICACHE_TAG_WIDTH-1:0]                tag_a;
    logic [ICACHE_TAG_WIDTH-1:0]                tag_b;
    logic [ICACHE_TAG_WIDTH-1:0]                tag_c;
    logic [L1_BLOCK_ADDR_WIDTH-1:0]             pa_a;
    logic [L1_BLOCK_ADDR_WIDTH-1:0]             pa_b;
    logic [L1_BLOCK_ADDR_WIDTH-1:0]             pa_c;

    icache_top icache_top_inst (.*);

    always #50 CLK = ~CLK;

    // ------------------------------
    // helpers

    // each 32-bit lane holds word number, lane number and block address
    function automatic logic [127:0] word_pattern(logic [L1_BLOCK_ADDR_WIDTH-1:0] pa, int w);
        logic [127:0] p;
        for (int j = 0; j < 4; j++) begin
            p[j*32 +: 32] = {w[0], j[1:0], pa};
        end
        return p;
    endfunction

    task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic abort_on_timeout(string what);
        $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
        $display("checks run: %0d, failed: %0d, timeouts: 1", checks, errors);
        $display("Test failures found");
        $finish;
    endtask

    // strobes last one cycle
    task automatic next_cycle();
        @(posedge CLK);
        #10;
        core_req_valid = 1'b0;
        core_resp_hit_valid = 1'b0;
        core_resp_miss_valid = 1'b0;
        l2_req_ready = 1'b0;
        l2_resp_valid = 1'b0;
    endtask

    // request, then tag compare and feedback in the response cycle
    task automatic lookup(logic [ICACHE_INDEX_WIDTH-1:0] idx, logic off,
                          logic [ICACHE_TAG_WIDTH-1:0] tag, logic feedback);
        logic hit0;
        logic hit1;
        core_req_valid = 1'b1;
        core_req_index = idx;
        core_req_block_offset = off;
        core_resp_miss_tag = tag;
        next_cycle();
        seen_valid = core_resp_valid_by_way;
        seen_tag = core_resp_tag_by_way;
        seen_data = core_resp_instr_16B_by_way;
        hit0 = seen_valid[0] & (seen_tag[0] == tag);
        hit1 = seen_valid[1] & (seen_tag[1] == tag);
        if (feedback) begin
            if (hit0 | hit1) begin
                core_resp_hit_valid = 1'b1;
                core_resp_hit_way = hit1;
            end
            else begin
                core_resp_miss_valid = 1'b1;
            end
        end
        next_cycle();
    endtask

    // L2 model, returns with the response pulse driven
    task automatic serve_miss(string name, logic [L1_BLOCK_ADDR_WIDTH-1:0] pa, logic corrupt);
        int n;
        int gap;
        n = 0;
        while (!l2_req_valid && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!l2_req_valid) begin
            abort_on_timeout({name, " L2 request"});
        end
        check_value({name, " request address"}, 128'(pa), 128'(l2_req_PA29));
        gap = $urandom_range(2, 5);
        repeat (gap) begin
            next_cycle();
            check_value({name, " request held"}, 128'(1), 128'(l2_req_valid));
            check_value({name, " address held"}, 128'(pa), 128'(l2_req_PA29));
        end
        l2_req_ready = 1'b1;
        next_cycle();
        check_value({name, " request taken"}, 128'(0), 128'(l2_req_valid));
        repeat (2) next_cycle();
        l2_resp_valid = 1'b1;
        l2_resp_PA29 = corrupt ? (pa ^ 29'h80) : pa;
        l2_resp_data256 = {word_pattern(pa, 1), word_pattern(pa, 0)};
    endtask

    // ------------------------------
    // test sequence

    initial begin
        nRST = 1'b0;
        core_req_valid = 1'b0;
        core_req_block_offset = '0;
        core_req_index = '0;
        core_resp_hit_valid = 1'b0;
        core_resp_hit_way = 1'b0;
        core_resp_miss_valid = 1'b0;
        core_resp_miss_tag = '0;
        l2_req_ready = 1'b0;
        l2_resp_valid = 1'b0;
        l2_resp_PA29 = '0;
        l2_resp_data256 = '0;
        void'($urandom(32'h46bf_c8bf));

        idx_a = ICACHE_INDEX_WIDTH'($urandom_range(0, 127));
        idx_c = idx_a ^ 7'h40;
        tag_a = ICACHE_TAG_WIDTH'($urandom());
        tag_b = tag_a ^ ICACHE_TAG_WIDTH'($urandom_range(1, 255));
        tag_c = ICACHE_TAG_WIDTH'($urandom());
        pa_a = {tag_a, idx_a};
        pa_b = {tag_b, idx_a};
        pa_c = {tag_c, idx_c};

        repeat (4) @(posedge CLK);
        #10;
        nRST = 1'b1;

        // empty cache
        repeat (6) begin
            lookup(ICACHE_INDEX_WIDTH'($urandom_range(0, 127)), 1'($urandom()),
                   ICACHE_TAG_WIDTH'($urandom()), 1'b0);
            check_value("reset valid bits", 128'(0), 128'(seen_valid));
        end

        // first miss lands in way 0
        lookup(idx_a, 1'b0, tag_a, 1'b1);
        check_value("first miss valid bits", 128'(0), 128'(seen_valid));
        serve_miss("first miss", pa_a, 1'b0);
        repeat (4) next_cycle();
        for (int off = 0; off < 2; off++) begin
            lookup(idx_a, off[0], tag_a, 1'b1);
            check_value("first fill valid bits", 128'(2'b01), 128'(seen_valid));
            check_value("first fill tag way 0", 128'(tag_a), 128'(seen_tag[0]));
            check_value("first fill data way 0", word_pattern(pa_a, off), seen_data[0]);
        end

        // way 1 is LRU after the hits, new tag goes there
        lookup(idx_a, 1'b0, tag_b, 1'b1);
        check_value("second miss valid bits", 128'(2'b01), 128'(seen_valid));
        serve_miss("second miss", pa_b, 1'b0);
        for (int off = 0; off < 2; off++) begin
            lookup(idx_a, off[0], tag_b, 1'b1);
            check_value("bypass valid bits", 128'(2'b11), 128'(seen_valid));
            check_value("bypass tag way 1", 128'(tag_b), 128'(seen_tag[1]));
            check_value("bypass data way 1", word_pattern(pa_b, off), seen_data[1]);
            check_value("bypass tag way 0", 128'(tag_a), 128'(seen_tag[0]));
            check_value("bypass data way 0", word_pattern(pa_a, off), seen_data[0]);
        end
        repeat (2) next_cycle();
        for (int off = 0; off < 2; off++) begin
            lookup(idx_a, off[0], tag_a, 1'b1);
            check_value("both ways valid bits", 128'(2'b11), 128'(seen_valid));
            check_value("both ways tag way 0", 128'(tag_a), 128'(seen_tag[0]));
            check_value("both ways data way 0", word_pattern(pa_a, off), seen_data[0]);
            check_value("both ways tag way 1", 128'(tag_b), 128'(seen_tag[1]));
            check_value("both ways data way 1", word_pattern(pa_b, off), seen_data[1]);
        end

        // response for another address is dropped
        lookup(idx_c, 1'b0, tag_c, 1'b1);
        serve_miss("bad response", pa_c, 1'b1);
        repeat (6) next_cycle();
        lookup(idx_c, 1'b0, tag_c, 1'b0);
        check_value("bad response valid bits", 128'(0), 128'(seen_valid));

        repeat (2) next_cycle();
        $display("checks run: %0d, failed: %0d, timeouts: 0", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end
        else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog/bram_1r1w.sv
`timescale 1ns/100ps

module bram_1r1w #(
    parameter int DATA_BYTES = 4,
    parameter int DEPTH = 64
) (
    input  logic                        CLK,
    input  logic                        nRST,

    input  logic                        ren,
    input  logic [$clog2(DEPTH)-1:0]    rindex,
    output logic [DATA_BYTES*8-1:0]     rdata,

    input  logic [DATA_BYTES-1:0]       wen_byte,
    input  logic [$clog2(DEPTH)-1:0]    windex,
    input  logic [DATA_BYTES*8-1:0]     wdata
);

    logic [DATA_BYTES-1:0][7:0] mem [DEPTH];

    // read returns the old contents on a same-cycle write
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            rdata <= '0;
            mem <= '{default: '0};
        end
        else begin
            if (ren) begin
                rdata <= mem[rindex];
            end
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][b] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- verilog/icache_cfg_pkg.sv
package icache_cfg_pkg;

    // ------------------------------
    // cache geometry

    localparam int ICACHE_NUM_SETS = 128;
    localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_NUM_SETS);
    localparam int ICACHE_TAG_WIDTH = 22;

    localparam int ICACHE_BLOCK_SIZE = 32;
    localparam int ICACHE_FETCH_WIDTH = 16;
    localparam int ICACHE_FETCH_WORDS = ICACHE_BLOCK_SIZE / ICACHE_FETCH_WIDTH;
    localparam int ICACHE_FETCH_OFFSET_WIDTH = $clog2(ICACHE_FETCH_WORDS);

    localparam int ICACHE_WAYS = 2;

    // tag entry rounded up to whole bytes for the tag RAM
    localparam int ICACHE_TAG_ENTRY_BYTES =
        (ICACHE_WAYS * (ICACHE_TAG_WIDTH + 1) + 7) / 8;

    // ------------------------------
    // types

    // both ways of one set, 46 bits
    typedef struct packed {
        logic [ICACHE_WAYS-1:0]                         valid_by_way;
        logic [ICACHE_WAYS-1:0][ICACHE_TAG_WIDTH-1:0]   tag_by_way;
    } tag_entry_t;

    // one 16B fetch word
    typedef logic [ICACHE_FETCH_WIDTH-1:0][7:0] fetch_word_t;

endpackage

//--- verilog/icache_ifaces.sv
`timescale 1ns/100ps

// registered core request and tag read, lookup -> miss unit
interface lookup_if;
    import icache_cfg_pkg::*;

    logic                                   resp_valid;
    logic [ICACHE_INDEX_WIDTH-1:0]          resp_index;
    logic [ICACHE_FETCH_OFFSET_WIDTH-1:0]   resp_offset;
    tag_entry_t                             resp_entry;
    logic                                   resp_lru_way;
    // core miss tag and resp index hit the miss register
    logic                                   miss_match;

    modport source (
        output resp_valid, resp_index, resp_offset, resp_entry, resp_lru_way, miss_match
    );
    modport sink (
        input resp_valid, resp_index, resp_offset, resp_entry, resp_lru_way, miss_match
    );
endinterface

// miss register state and fill writes, miss unit -> lookup
interface fill_if;
    import icache_cfg_pkg::*;
    import icache_l2_pkg::*;

    logic                                   active;
    logic [ICACHE_INDEX_WIDTH-1:0]          index;
    logic [ICACHE_TAG_WIDTH-1:0]            tag;
    logic                                   way;
    logic                                   other_valid;
    logic [ICACHE_TAG_WIDTH-1:0]            other_tag;
    logic                                   write;
    logic [ICACHE_FETCH_OFFSET_WIDTH-1:0]   word_sel;
    fetch_word_t                            word;
    logic                                   bypass;
    block_data_t                            block;

    modport source (
        output active, index, tag, way, other_valid, other_tag,
        output write, word_sel, word, bypass, block
    );
    modport sink (
        input active, index, tag, way, other_valid, other_tag,
        input write, word_sel, word, bypass, block
    );
endinterface

//--- verilog/icache_l2_pkg.sv
package icache_l2_pkg;

    // ------------------------------
    // L2 side widths

    localparam int L1_BLOCK_ADDR_WIDTH =
        icache_cfg_pkg::ICACHE_TAG_WIDTH + icache_cfg_pkg::ICACHE_INDEX_WIDTH;
    localparam int L1_BLOCK_SIZE_BITS = icache_cfg_pkg::ICACHE_BLOCK_SIZE * 8;

    // ------------------------------
    // block address

    typedef struct packed {
        logic [icache_cfg_pkg::ICACHE_TAG_WIDTH-1:0]    tag;
        logic [icache_cfg_pkg::ICACHE_INDEX_WIDTH-1:0]  index;
    } block_addr_fields_t;

    // flat word on the L2 bus, or split into tag and set index
    typedef union packed {
        logic [L1_BLOCK_ADDR_WIDTH-1:0] flat;
        block_addr_fields_t             fields;
    } block_addr_t;

    // whole block, word 0 in the low half
    typedef icache_cfg_pkg::fetch_word_t [icache_cfg_pkg::ICACHE_FETCH_WORDS-1:0]
        block_data_t;

endpackage

//--- verilog/icache_lookup.sv
`timescale 1ns/100ps

module icache_lookup (
    input  logic CLK,
    input  logic nRST,

    // core request
    input  logic                                                core_req_valid,
    input  logic [icache_cfg_pkg::ICACHE_FETCH_OFFSET_WIDTH-1:0] core_req_block_offset,
    input  logic [icache_cfg_pkg::ICACHE_INDEX_WIDTH-1:0]       core_req_index,

    // core response
    output logic [icache_cfg_pkg::ICACHE_WAYS-1:0]              core_resp_valid_by_way,
    output logic [icache_cfg_pkg::ICACHE_WAYS-1:0][icache_cfg_pkg::ICACHE_TAG_WIDTH-1:0]
                                                                core_resp_tag_by_way,
    output icache_cfg_pkg::fetch_word_t [icache_cfg_pkg::ICACHE_WAYS-1:0]
                                                                core_resp_instr_16B_by_way,

    // core feedback
    input  logic                                                core_resp_hit_valid,
    input  logic                                                core_resp_hit_way,
    input  logic [icache_cfg_pkg::ICACHE_TAG_WIDTH-1:0]         core_resp_miss_tag,

    lookup_if.source                                            lk,
    fill_if.sink                                                fl
);

    import icache_cfg_pkg::*;

    // ------------------------------
    // signals

    logic [ICACHE_TAG_ENTRY_BYTES*8-1:0]                tag_rdata;
    tag_entry_t                                         tag_wentry;

    fetch_word_t [ICACHE_WAYS-1:0]                      data_rdata;
    logic [ICACHE_WAYS-1:0][ICACHE_FETCH_WIDTH-1:0]     data_wmask;

    logic [ICACHE_NUM_SETS-1:0]                         lru;

    // ------------------------------
    // request stage

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            lk.resp_valid <= 1'b0;
            lk.resp_index <= '0;
            lk.resp_offset <= '0;
        end
        else begin
            lk.resp_valid <= core_req_valid;
            lk.resp_index <= core_req_index;
            lk.resp_offset <= core_req_block_offset;
        end
    end

    assign lk.resp_entry = tag_rdata[$bits(tag_entry_t)-1:0];
    assign lk.resp_lru_way = lru[lk.resp_index];

    // one comparison against the miss register, shared with the miss unit
    assign lk.miss_match = lk.resp_valid & fl.active
        & (lk.resp_index == fl.index) & (core_resp_miss_tag == fl.tag);

    // ------------------------------
    // fill writes

    always_comb begin
        // fill way stays invalid until its last word lands
        tag_wentry.valid_by_way[fl.way] = (fl.word_sel == '1);
        tag_wentry.tag_by_way[fl.way] = fl.tag;
        tag_wentry.valid_by_way[~fl.way] = fl.other_valid;
        tag_wentry.tag_by_way[~fl.way] = fl.other_tag;

        data_wmask = '0;
        if (fl.write) begin
            data_wmask[fl.way] = '1;
        end
    end

    bram_1r1w #(
        .DATA_BYTES(ICACHE_TAG_ENTRY_BYTES),
        .DEPTH(ICACHE_NUM_SETS)
    ) tag_array (
        .CLK(CLK),
        .nRST(nRST),
        .ren(core_req_valid),
        .rindex(core_req_index),
        .rdata(tag_rdata),
        .wen_byte({ICACHE_TAG_ENTRY_BYTES{fl.write}}),
        .windex(fl.index),
        .wdata({{(ICACHE_TAG_ENTRY_BYTES*8 - $bits(tag_entry_t)){1'b0}}, tag_wentry})
    );

    // one row per fetch word, both ways side by side
    bram_1r1w #(
        .DATA_BYTES(ICACHE_WAYS * ICACHE_FETCH_WIDTH),
        .DEPTH(ICACHE_NUM_SETS * ICACHE_FETCH_WORDS)
    ) data_array (
        .CLK(CLK),
        .nRST(nRST),
        .ren(core_req_valid),
        .rindex({core_req_index, core_req_block_offset}),
        .rdata(data_rdata),
        .wen_byte(data_wmask),
        .windex({fl.index, fl.word_sel}),
        .wdata({ICACHE_WAYS{fl.word}})
    );

    // ------------------------------
    // LRU bits

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            lru <= '0;
        end
        else if (core_resp_hit_valid) begin
            lru[lk.resp_index] <= ~core_resp_hit_way;
        end
    end

    // ------------------------------
    // response with miss bypass

    always_comb begin
        core_resp_valid_by_way = lk.resp_entry.valid_by_way;
        core_resp_tag_by_way = lk.resp_entry.tag_by_way;
        core_resp_instr_16B_by_way = data_rdata;

        // block still filling, answer from the buffer in the fill way
        if (lk.miss_match & fl.bypass) begin
            core_resp_valid_by_way[fl.way] = 1'b1;
            core_resp_tag_by_way[fl.way] = fl.tag;
            core_resp_instr_16B_by_way[fl.way] = fl.block[lk.resp_offset];
        end
    end

endmodule

//--- verilog/icache_miss_unit.sv
`timescale 1ns/100ps

module icache_miss_unit (
    input  logic CLK,
    input  logic nRST,

    // core feedback
    input  logic                                            core_resp_miss_valid,
    input  logic [icache_cfg_pkg::ICACHE_TAG_WIDTH-1:0]     core_resp_miss_tag,

    // L2 request
    output logic                                            l2_req_valid,
    output logic [icache_l2_pkg::L1_BLOCK_ADDR_WIDTH-1:0]   l2_req_PA29,
    input  logic                                            l2_req_ready,

    // L2 response
    input  logic                                            l2_resp_valid,
    input  logic [icache_l2_pkg::L1_BLOCK_ADDR_WIDTH-1:0]   l2_resp_PA29,
    input  icache_l2_pkg::block_data_t                      l2_resp_data256,

    lookup_if.sink                                          lk,
    fill_if.source                                          fl
);

    import icache_cfg_pkg::*;
    import icache_l2_pkg::*;

    // ------------------------------
    // miss register

    logic                                   valid, next_valid;
    logic                                   requested, next_requested;
    logic [ICACHE_INDEX_WIDTH-1:0]          index, next_index;
    logic [ICACHE_TAG_WIDTH-1:0]            tag, next_tag;
    logic                                   way, next_way;
    logic                                   other_valid, next_other_valid;
    logic [ICACHE_TAG_WIDTH-1:0]            other_tag, next_other_tag;
    logic                                   data_valid, next_data_valid;
    logic [ICACHE_FETCH_OFFSET_WIDTH-1:0]   word_cnt, next_word_cnt;
    block_data_t                            buffer, next_buffer;
    logic                                   delay, next_delay;

    block_addr_t                            req_addr;
    block_addr_t                            resp_addr;
    logic                                   resp_match;

    // ------------------------------
    // L2 address views

    always_comb begin
        req_addr.fields.tag = tag;
        req_addr.fields.index = index;
        resp_addr.flat = l2_resp_PA29;
        resp_match = l2_resp_valid
            & (resp_addr.fields.tag == tag) & (resp_addr.fields.index == index);
    end

    assign l2_req_valid = valid & ~requested;
    assign l2_req_PA29 = req_addr.flat;

    // ------------------------------
    // next state

    always_comb begin
        next_valid = valid;
        next_requested = requested;
        next_index = index;
        next_tag = tag;
        next_way = way;
        next_other_valid = other_valid;
        next_other_tag = other_tag;
        next_data_valid = data_valid;
        next_word_cnt = word_cnt;
        next_buffer = buffer;
        next_delay = 1'b0;

        // fill words ahead of the last one
        if (valid & data_valid & (word_cnt != '1)) begin
            next_word_cnt = word_cnt + 1'b1;
        end
        // new miss, unless it is the block already held
        else if (core_resp_miss_valid & lk.resp_valid & (~valid | ~lk.miss_match)) begin
            next_valid = 1'b1;
            next_requested = 1'b0;
            next_index = lk.resp_index;
            next_tag = core_resp_miss_tag;
            next_way = lk.resp_lru_way;
            next_other_valid = lk.resp_entry.valid_by_way[~lk.resp_lru_way];
            next_other_tag = lk.resp_entry.tag_by_way[~lk.resp_lru_way];
            next_data_valid = 1'b0;
            next_word_cnt = '0;
        end
        // last word written this cycle
        else if (valid & data_valid) begin
            next_data_valid = 1'b0;
            next_delay = 1'b1;
        end
        else if (valid & delay) begin
            next_valid = 1'b0;
        end
        // waiting on L2
        else if (valid) begin
            if (resp_match) begin
                next_requested = 1'b1;
                next_data_valid = 1'b1;
                next_buffer = l2_resp_data256;
            end
            else if (~requested & l2_req_ready) begin
                next_requested = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid <= 1'b0;
            requested <= 1'b0;
            index <= '0;
            tag <= '0;
            way <= 1'b0;
            data_valid <= 1'b0;
            word_cnt <= '0;
            delay <= 1'b0;
        end
        else begin
            valid <= next_valid;
            requested <= next_requested;
            index <= next_index;
            tag <= next_tag;
            way <= next_way;
            data_valid <= next_data_valid;
            word_cnt <= next_word_cnt;
            delay <= next_delay;
        end
    end

    always_ff @(posedge CLK) begin
        other_valid <= next_other_valid;
        other_tag <= next_other_tag;
        buffer <= next_buffer;
    end

    // ------------------------------
    // fill outputs

    assign fl.active = valid;
    assign fl.index = index;
    assign fl.tag = tag;
    assign fl.way = way;
    assign fl.other_valid = other_valid;
    assign fl.other_tag = other_tag;
    assign fl.write = valid & data_valid;
    assign fl.word_sel = word_cnt;
    assign fl.word = buffer[word_cnt];
    // buffer holds the block from acceptance through the delay cycle
    assign fl.bypass = valid & (data_valid | delay);
    assign fl.block = buffer;

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/100ps

module icache_top (
    input  logic CLK,
    input  logic nRST,

    // req from core
    input  logic                                                core_req_valid,
    input  logic [icache_cfg_pkg::ICACHE_FETCH_OFFSET_WIDTH-1:0] core_req_block_offset,
    input  logic [icache_cfg_pkg::ICACHE_INDEX_WIDTH-1:0]       core_req_index,

    // resp to core
    output logic [1:0]                                          core_resp_valid_by_way,
    output logic [1:0][icache_cfg_pkg::ICACHE_TAG_WIDTH-1:0]    core_resp_tag_by_way,
    output logic [1:0][icache_cfg_pkg::ICACHE_FETCH_WIDTH-1:0][7:0]
                                                                core_resp_instr_16B_by_way,

    // feedback from core
    input  logic                                                core_resp_hit_valid,
    input  logic                                                core_resp_hit_way,
    input  logic                                                core_resp_miss_valid,
    input  logic [icache_cfg_pkg::ICACHE_TAG_WIDTH-1:0]         core_resp_miss_tag,

    // req to L2
    output logic                                                l2_req_valid,
    output logic [icache_l2_pkg::L1_BLOCK_ADDR_WIDTH-1:0]       l2_req_PA29,
    input  logic                                                l2_req_ready,

    // resp from L2
    input  logic                                                l2_resp_valid,
    input  logic [icache_l2_pkg::L1_BLOCK_ADDR_WIDTH-1:0]       l2_resp_PA29,
    input  logic [icache_l2_pkg::L1_BLOCK_SIZE_BITS-1:0]        l2_resp_data256
);

    lookup_if lk ();
    fill_if fl ();

    icache_lookup lookup_inst (
        .CLK(CLK),
        .nRST(nRST),
        .core_req_valid(core_req_valid),
        .core_req_block_offset(core_req_block_offset),
        .core_req_index(core_req_index),
        .core_resp_valid_by_way(core_resp_valid_by_way),
        .core_resp_tag_by_way(core_resp_tag_by_way),
        .core_resp_instr_16B_by_way(core_resp_instr_16B_by_way),
        .core_resp_hit_valid(core_resp_hit_valid),
        .core_resp_hit_way(core_resp_hit_way),
        .core_resp_miss_tag(core_resp_miss_tag),
        .lk(lk.source),
        .fl(fl.sink)
    );

    icache_miss_unit miss_unit_inst (
        .CLK(CLK),
        .nRST(nRST),
        .core_resp_miss_valid(core_resp_miss_valid),
        .core_resp_miss_tag(core_resp_miss_tag),
        .l2_req_valid(l2_req_valid),
        .l2_req_PA29(l2_req_PA29),
        .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid),
        .l2_resp_PA29(l2_resp_PA29),
        .l2_resp_data256(l2_resp_data256),
        .lk(lk.sink),
        .fl(fl.source)
    );

endmodule
